/* hci_arbiter.sv */
// round-robin arbiter with forced-priority override for the hci request mux
`timescale 1ns/1ps

module hci_arbiter #(
  parameter int unsigned NB_CHAN = 4
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    clear_i,
  input  logic                                    priority_force_i,
  input  logic [NB_CHAN-1:0][$clog2(NB_CHAN)-1:0] priority_i,
  input  logic [NB_CHAN-1:0]                      req,
  input  logic                                    accept,
  output logic [$clog2(NB_CHAN)-1:0]              winner
);

  localparam int unsigned CW = $clog2(NB_CHAN);

  // rotation counter, names the channel at rank zero in round-robin mode
  logic [CW-1:0] rr_counter_q;

  // rank table, entry k holds the channel index sitting at rank k
  logic [NB_CHAN-1:0][CW-1:0] rank;

  // counter moves on every accepted request
  // clear brings it back to channel zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_counter_q <= '0;
    end else if (clear_i) begin
      rr_counter_q <= '0;
    end else if (accept) begin
      // explicit wrap, NB_CHAN need not be a power of two
      if (rr_counter_q == CW'(NB_CHAN - 1)) begin
        rr_counter_q <= '0;
      end else begin
        rr_counter_q <= rr_counter_q + CW'(1);
      end
    end
  end

  // build the rank table
  // forced mode takes the outside table as is
  // round-robin mode rotates the channel list by the counter
  always_comb begin
    for (int k = 0; k < NB_CHAN; k++) begin
      if (priority_force_i) begin
        rank[k] = priority_i[k];
      end else begin
        rank[k] = CW'((int'(rr_counter_q) + k) % int'(NB_CHAN));
      end
    end
  end

  // winner search
  // walk from the last rank toward rank zero, a later hit overrides an earlier one,
  // so the requester at the lowest rank is left standing
  // with no request at all the counter value is kept
  always_comb begin
    winner = rr_counter_q;
    for (int jj = 0; jj < NB_CHAN; jj++) begin
      if (req[rank[NB_CHAN-1-jj]]) begin
        winner = rank[NB_CHAN-1-jj];
      end
    end
  end

endmodule

/* hci_mem_bank.sv */
// single-port memory bank with byte enables and a two-entry tagged response queue
`timescale 1ns/1ps

module hci_mem_bank (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req,
  input  hci_pkg::hci_req_t payload,
  output logic              gnt,
  output logic              r_valid,
  output hci_pkg::hci_rsp_t rsp,
  input  logic              r_ready
);

  localparam int unsigned NB_WORDS = 2 ** hci_pkg::AW;
  localparam int unsigned NB_BYTES = hci_pkg::DW / 8;

  // storage array, contents start unknown
  logic [hci_pkg::DW-1:0] mem_q [NB_WORDS];

  // response queue, two slots addressed by one-bit pointers
  hci_pkg::hci_rsp_t fifo_q [2];
  logic              wr_ptr_q;
  logic              rd_ptr_q;
  logic [1:0]        count_q;

  logic              push;
  logic              pop;
  hci_pkg::hci_rsp_t rsp_d;

  // head of the queue is shown whenever something is stored
  assign r_valid = (count_q != 2'd0);
  assign rsp     = fifo_q[rd_ptr_q];
  assign pop     = r_valid & r_ready;

  // room for one more, or a full queue freeing its head right now
  assign gnt  = (count_q != 2'd2) | pop;
  assign push = req & gnt;

  // response built in the accepting cycle
  // reads return the stored word, writes return zero
  always_comb begin
    rsp_d.r_id   = payload.id;
    rsp_d.r_data = payload.wen ? mem_q[payload.add] : '0;
  end

  // byte-wise write, only enabled lanes change
  always_ff @(posedge clk_i) begin
    if (push && !payload.wen) begin
      for (int b = 0; b < NB_BYTES; b++) begin
        if (payload.be[b]) begin
          mem_q[payload.add][8*b +: 8] <= payload.data[8*b +: 8];
        end
      end
    end
  end

  // when full with a pop in the same cycle, the write slot equals the head slot
  // and the head leaves at this same edge
  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= rsp_d;
    end
  end

  // queue pointers and fill level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* hci_mux_assert.sv */
// handshake checks on the hci mux top level, bound into every instance
`timescale 1ns/1ps

module hci_mux_assert #(
  parameter int unsigned NB_CHAN = 4
) (
  input logic               clk_i,
  input logic               rst_ni,
  input logic [NB_CHAN-1:0] in_req,
  input logic [NB_CHAN-1:0] in_gnt,
  input logic [NB_CHAN-1:0] in_r_valid,
  input logic [NB_CHAN-1:0] in_r_ready,
  input hci_pkg::hci_rsp_t  in_rsp
);

  // one grant at most per cycle
  gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(in_gnt)) else $error("more than one in_gnt high");

  // a grant only where a request stands
  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (in_gnt & ~in_req) == '0) else $error("in_gnt high without in_req");

  // the tag names one channel only
  valid_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(in_r_valid)) else $error("more than one in_r_valid high");

  // stalled response held unchanged
  rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|(in_r_valid & ~in_r_ready)) |=> ($stable(in_rsp) && $stable(in_r_valid)))
    else $error("stalled response changed");

endmodule

bind hci_mux_top hci_mux_assert #(
  .NB_CHAN (NB_CHAN)
) i_mux_assert (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .in_req     (in_req),
  .in_gnt     (in_gnt),
  .in_r_valid (in_r_valid),
  .in_r_ready (in_r_ready),
  .in_rsp     (in_rsp)
);

/* hci_mux_top.sv */
// N-to-1 hci multiplexer in front of one memory bank, responses routed by tag
`timescale 1ns/1ps

module hci_mux_top #(
  parameter int unsigned NB_CHAN = 4
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    clear_i,
  input  logic                                    priority_force_i,
  input  logic [NB_CHAN-1:0][$clog2(NB_CHAN)-1:0] priority_i,
  input  logic [NB_CHAN-1:0]                      in_req,
  output logic [NB_CHAN-1:0]                      in_gnt,
  input  hci_pkg::hci_req_t [NB_CHAN-1:0]         in_payload,
  output logic [NB_CHAN-1:0]                      in_r_valid,
  input  logic [NB_CHAN-1:0]                      in_r_ready,
  output hci_pkg::hci_rsp_t                       in_rsp
);

  // arbitration result
  logic [$clog2(NB_CHAN)-1:0] winner;

  // bank side handshake and payloads
  logic              out_req;
  logic              out_gnt;
  logic              out_r_valid;
  logic              out_r_ready;
  hci_pkg::hci_req_t out_payload;
  hci_pkg::hci_rsp_t out_rsp;

  // request accepted by the bank, steps the rotation
  logic accept;
  assign accept = out_req & out_gnt;

  // response data is the same for every channel, only valid is routed
  assign in_rsp = out_rsp;

  hci_arbiter #(
    .NB_CHAN (NB_CHAN)
  ) i_arbiter (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .clear_i          (clear_i),
    .priority_force_i (priority_force_i),
    .priority_i       (priority_i),
    .req              (in_req),
    .accept           (accept),
    .winner           (winner)
  );

  hci_req_mux #(
    .NB_CHAN (NB_CHAN)
  ) i_req_mux (
    .winner      (winner),
    .in_req      (in_req),
    .in_payload  (in_payload),
    .out_gnt     (out_gnt),
    .in_gnt      (in_gnt),
    .out_req     (out_req),
    .out_payload (out_payload)
  );

  hci_rsp_demux #(
    .NB_CHAN (NB_CHAN)
  ) i_rsp_demux (
    .out_r_valid (out_r_valid),
    .out_rsp     (out_rsp),
    .in_r_ready  (in_r_ready),
    .in_r_valid  (in_r_valid),
    .out_r_ready (out_r_ready)
  );

  hci_mem_bank i_mem_bank (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req     (out_req),
    .payload (out_payload),
    .gnt     (out_gnt),
    .r_valid (out_r_valid),
    .rsp     (out_rsp),
    .r_ready (out_r_ready)
  );

endmodule

/* hci_pkg.sv */
// hci shared-memory subsystem types, widths and request/response structs
package hci_pkg;

  // upper bound on initiator channels
  // it sizes the tag carried with each request
  localparam int unsigned NB_CHAN_MAX = 8;

  // word address width, 64 words in the bank
  localparam int unsigned AW = 6;

  // data width of one memory word
  localparam int unsigned DW = 32;

  // tag width, wide enough for any channel index up to the bound
  localparam int unsigned IW = $clog2(NB_CHAN_MAX);

  // request toward the bank
  // wen high selects a read, low selects a write
  // be carries one enable per data byte
  // id is filled by the mux with the winning channel number
  typedef struct packed {
    logic [AW-1:0]   add;
    logic            wen;
    logic [DW-1:0]   data;
    logic [DW/8-1:0] be;
    logic [IW-1:0]   id;
  } hci_req_t;

  // response from the bank
  // r_id echoes the request tag and alone decides the destination
  // write responses return zero data
  typedef struct packed {
    logic [DW-1:0] r_data;
    logic [IW-1:0] r_id;
  } hci_rsp_t;

endpackage

/* hci_req_mux.sv */
// request datapath selecting the winning channel, tagging it and returning grants
`timescale 1ns/1ps

module hci_req_mux #(
  parameter int unsigned NB_CHAN = 4
) (
  input  logic [$clog2(NB_CHAN)-1:0]          winner,
  input  logic [NB_CHAN-1:0]                  in_req,
  input  hci_pkg::hci_req_t [NB_CHAN-1:0]     in_payload,
  input  logic                                out_gnt,
  output logic [NB_CHAN-1:0]                  in_gnt,
  output logic                                out_req,
  output hci_pkg::hci_req_t                   out_payload
);

  localparam int unsigned CW = $clog2(NB_CHAN);

  // winner's payload before the tag is stamped
  hci_pkg::hci_req_t sel_payload;

  // forward the winner's strobe to the bank
  assign out_req = in_req[winner];

  // channel id field is ignored on input
  // the tag is replaced by the winner index so the response finds its way back
  always_comb begin
    sel_payload    = in_payload[winner];
    sel_payload.id = hci_pkg::IW'(winner);
    out_payload    = sel_payload;
  end

  // grant only the winner, only if it is really asking and the bank takes it
  for (genvar ii = 0; ii < NB_CHAN; ii++) begin : gen_gnt
    assign in_gnt[ii] = (winner == CW'(ii)) & in_req[ii] & out_gnt;
  end

endmodule

/* hci_rsp_demux.sv */
// response datapath routing the bank's valid by tag and returning the owner's ready
`timescale 1ns/1ps

module hci_rsp_demux #(
  parameter int unsigned NB_CHAN = 4
) (
  input  logic                     out_r_valid,
  input  hci_pkg::hci_rsp_t        out_rsp,
  input  logic [NB_CHAN-1:0]       in_r_ready,
  output logic [NB_CHAN-1:0]       in_r_valid,
  output logic                     out_r_ready
);

  // one-hot decode of the tag
  logic [NB_CHAN-1:0] tag_hit;

  for (genvar ii = 0; ii < NB_CHAN; ii++) begin : gen_hit
    assign tag_hit[ii] = (out_rsp.r_id == hci_pkg::IW'(ii));
  end

  // valid goes only to the channel named by the tag
  assign in_r_valid = tag_hit & {NB_CHAN{out_r_valid}};

  // ready back to the bank comes from that same channel
  // a tag outside the channel range matches nobody and stalls the bank
  always_comb begin
    out_r_ready = 1'b0;
    for (int ii = 0; ii < NB_CHAN; ii++) begin
      if (tag_hit[ii]) begin
        out_r_ready = in_r_ready[ii];
      end
    end
  end

endmodule

/* tb_hci_mux.sv */
// testbench for the hci mux subsystem, random traffic checked against a memory and arbiter model
`timescale 1ns/1ps

module tb_hci_mux;

  localparam int unsigned NB_CHAN = 4;
  localparam int unsigned CW      = $clog2(NB_CHAN);
  localparam int unsigned WPC     = (2 ** hci_pkg::AW) / NB_CHAN;
  // requests per channel in each test
  localparam int OPS_INIT  = WPC;
  localparam int OPS_BE    = 24;
  localparam int OPS_RR    = 20;
  localparam int OPS_FORCE = 20;
  localparam int OPS_BP    = 20;
  localparam int OPS_CLR   = 20;
  // one test lasts about one cycle per request over all channels
  localparam int CYCLE_LIMIT =
    4 * NB_CHAN * (OPS_INIT + OPS_BE + OPS_RR + OPS_FORCE + OPS_BP + OPS_CLR);

  logic                            clk_i = 1'b0;
  logic                            rst_ni;
  logic                            clear_i;
  logic                            priority_force_i;
  logic [NB_CHAN-1:0][CW-1:0]      priority_i;
  logic [NB_CHAN-1:0]              in_req;
  logic [NB_CHAN-1:0]              in_gnt;
  hci_pkg::hci_req_t [NB_CHAN-1:0] in_payload;
  logic [NB_CHAN-1:0]              in_r_valid;
  logic [NB_CHAN-1:0]              in_r_ready;
  hci_pkg::hci_rsp_t               in_rsp;

  // model state
  logic [31:0]            rng_state = 32'h7e2f;
  logic [hci_pkg::DW-1:0] mem_m [2 ** hci_pkg::AW];
  logic [CW-1:0]          rr_m;
  // channel order of the responses waiting in the bank queue
  int                     order_q [$];
  // expected responses, one queue per channel
  hci_pkg::hci_rsp_t      exp_q [NB_CHAN][$];
  logic [NB_CHAN-1:0]     busy;
  logic [NB_CHAN-1:0]     outst;
  hci_pkg::hci_req_t      op_m [NB_CHAN];
  int                     ops_left [NB_CHAN];
  logic [hci_pkg::AW-1:0] last_add [NB_CHAN];
  int                     mode;
  int                     test_cyc;
  int                     cycle_cnt = 0;
  int                     errors;
  int                     checks;

  hci_mux_top #(
    .NB_CHAN (NB_CHAN)
  ) DUT (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .clear_i          (clear_i),
    .priority_force_i (priority_force_i),
    .priority_i       (priority_i),
    .in_req           (in_req),
    .in_gnt           (in_gnt),
    .in_payload       (in_payload),
    .in_r_valid       (in_r_valid),
    .in_r_ready       (in_r_ready),
    .in_rsp           (in_rsp)
  );

  always #4 clk_i = ~clk_i;

  // watchdog over the whole run
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: traffic did not drain within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  // xorshift32 generator
  function automatic logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // next request of channel c, shaped by the running test
  function automatic hci_pkg::hci_req_t make_op(int c);
    hci_pkg::hci_req_t op;
    logic [31:0]       r;
    r       = rand32();
    op.data = rand32();
    op.id   = r[31:29];
    op.be   = r[3:0];
    op.wen  = r[4];
    op.add  = r[10:5];
    case (mode)
      1: begin
        // own region, one word per request, full enables
        op.add = hci_pkg::AW'(c * WPC + (WPC - ops_left[c]));
        op.wen = 1'b0;
        op.be  = '1;
      end
      2: begin
        // write then read back the same word
        if (ops_left[c] % 2 == 0) begin
          op.add      = hci_pkg::AW'(c * WPC + int'(r[15:12]) % WPC);
          op.wen      = 1'b0;
          last_add[c] = op.add;
        end else begin
          op.add = last_add[c];
          op.wen = 1'b1;
        end
      end
      default: ;
    endcase
    return op;
  endfunction

  // lowest-rank requester, else the counter
  function automatic int model_winner();
    int ch;
    for (int k = 0; k < NB_CHAN; k++) begin
      ch = priority_force_i ? int'(priority_i[k]) : (int'(rr_m) + k) % NB_CHAN;
      if (in_req[ch]) begin
        return ch;
      end
    end
    return int'(rr_m);
  endfunction

  // random permutation of the channels into priority_i
  task automatic shuffle_priority();
    int            j;
    logic [CW-1:0] t;
    logic [31:0]   r;
    for (int k = 0; k < NB_CHAN; k++) begin
      priority_i[k] = CW'(k);
    end
    for (int k = NB_CHAN - 1; k > 0; k--) begin
      r             = rand32();
      j             = int'(r % (k + 1));
      t             = priority_i[k];
      priority_i[k] = priority_i[j];
      priority_i[j] = t;
    end
  endtask

  task automatic check_gnt(logic [NB_CHAN-1:0] got, logic [NB_CHAN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: in_gnt = %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_valid(logic [NB_CHAN-1:0] got, logic [NB_CHAN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: in_r_valid = %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_rsp(hci_pkg::hci_rsp_t got, hci_pkg::hci_rsp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: in_rsp = %h/%0d, expected %h/%0d",
               $time, got.r_data, got.r_id, exp.r_data, exp.r_id);
    end
  endtask

  // one clock: drive at the falling edge, check, then step the model past the rising edge
  task automatic step();
    int                 win;
    int                 head;
    logic               bank_gnt;
    logic               pop;
    logic               accept;
    logic [NB_CHAN-1:0] exp_gnt;
    logic [NB_CHAN-1:0] exp_valid;
    hci_pkg::hci_rsp_t  rsp;
    logic [31:0]        r;
    @(negedge clk_i);
    test_cyc++;
    for (int c = 0; c < NB_CHAN; c++) begin
      r = rand32();
      if (!busy[c] && !outst[c] && ops_left[c] > 0 && r[1:0] != 2'd0) begin
        op_m[c] = make_op(c);
        ops_left[c]--;
        busy[c] = 1'b1;
      end
      in_req[c]     = busy[c];
      in_payload[c] = op_m[c];
      in_r_ready[c] = (mode == 5) ? r[8] : 1'b1;
    end
    priority_force_i = (mode == 4);
    if (mode == 4) begin
      shuffle_priority();
    end
    clear_i = (mode == 6) && (test_cyc % 16 == 0);
    #1;
    head     = (order_q.size() > 0) ? order_q[0] : -1;
    pop      = (head >= 0) && in_r_ready[head];
    bank_gnt = (order_q.size() < 2) || pop;
    win      = model_winner();
    accept   = in_req[win] && bank_gnt;
    exp_gnt  = '0;
    if (accept) begin
      exp_gnt[win] = 1'b1;
    end
    exp_valid = '0;
    if (head >= 0) begin
      exp_valid[head] = 1'b1;
    end
    check_gnt(in_gnt, exp_gnt);
    check_valid(in_r_valid, exp_valid);
    if (head >= 0) begin
      check_rsp(in_rsp, exp_q[head][0]);
    end
    if (pop) begin
      void'(order_q.pop_front());
      outst[head] = 1'b0;
    end
    // an expected response leaves only when the DUT hands it over
    for (int c = 0; c < NB_CHAN; c++) begin
      if (in_r_valid[c] && in_r_ready[c] && exp_q[c].size() > 0) begin
        void'(exp_q[c].pop_front());
      end
    end
    if (accept) begin
      rsp.r_id = hci_pkg::IW'(win);
      if (op_m[win].wen) begin
        rsp.r_data = mem_m[op_m[win].add];
      end else begin
        rsp.r_data = '0;
        for (int b = 0; b < hci_pkg::DW / 8; b++) begin
          if (op_m[win].be[b]) begin
            mem_m[op_m[win].add][8*b +: 8] = op_m[win].data[8*b +: 8];
          end
        end
      end
      order_q.push_back(win);
      exp_q[win].push_back(rsp);
      busy[win]  = 1'b0;
      outst[win] = 1'b1;
    end
    // clear wins over a grant in the same cycle
    if (clear_i) begin
      rr_m = '0;
    end else if (accept) begin
      rr_m = (int'(rr_m) == NB_CHAN - 1) ? '0 : rr_m + CW'(1);
    end
  endtask

  task automatic run_test(int m, int ops, string name);
    int   err_start;
    logic idle;
    err_start = errors;
    mode      = m;
    test_cyc  = 0;
    for (int c = 0; c < NB_CHAN; c++) begin
      ops_left[c] = ops;
    end
    idle = 1'b0;
    while (!idle) begin
      step();
      idle = (order_q.size() == 0);
      for (int c = 0; c < NB_CHAN; c++) begin
        if (ops_left[c] > 0 || busy[c] || outst[c]) begin
          idle = 1'b0;
        end
      end
    end
    for (int c = 0; c < NB_CHAN; c++) begin
      if (exp_q[c].size() != 0) begin
        errors++;
        $display("channel %0d still expects %0d responses", c, exp_q[c].size());
      end
    end
    $display("test %0d %s: %0s, %0d errors", m, name,
             (errors == err_start) ? "ok" : "bad", errors - err_start);
  endtask

  initial begin
    rst_ni           = 1'b0;
    clear_i          = 1'b0;
    priority_force_i = 1'b0;
    priority_i       = '0;
    in_req           = '0;
    in_payload       = '0;
    in_r_ready       = '0;
    rr_m             = '0;
    busy             = '0;
    outst            = '0;
    mode             = 0;
    test_cyc         = 0;
    errors           = 0;
    checks           = 0;
    for (int c = 0; c < NB_CHAN; c++) begin
      ops_left[c] = 0;
      op_m[c]     = '0;
      last_add[c] = '0;
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    run_test(1, OPS_INIT, "init writes");
    run_test(2, OPS_BE, "byte-enable read-back");
    run_test(3, OPS_RR, "round-robin");
    run_test(4, OPS_FORCE, "forced priority");
    run_test(5, OPS_BP, "back-pressure");
    run_test(6, OPS_CLR, "clear");
    // idle tail, any late or repeated response shows up here
    mode = 0;
    repeat (4) step();
    $display("summary: 6 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
hci_pkg.sv
hci_arbiter.sv
hci_req_mux.sv
hci_rsp_demux.sv
hci_mem_bank.sv
hci_mux_top.sv
hci_mux_assert.sv
tb_hci_mux.sv
